// File: lanzonesPkg.sv
`default_nettype none

package lanzonesPkg;

   localparam int xlen     = 32;
   localparam int regAddrW = 5;
   localparam int numRegs  = 32;

   localparam logic [6:0] opOpImm = 7'b0010011;
   localparam logic [6:0] opOp    = 7'b0110011;
   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opHalt  = 7'h7F;

   localparam logic [2:0] f3Add  = 3'b000; // also sub
   localparam logic [2:0] f3Sll  = 3'b001;
   localparam logic [2:0] f3Slt  = 3'b010;
   localparam logic [2:0] f3Sltu = 3'b011;
   localparam logic [2:0] f3Xor  = 3'b100;
   localparam logic [2:0] f3Srl  = 3'b101; // also sra
   localparam logic [2:0] f3Or   = 3'b110;
   localparam logic [2:0] f3And  = 3'b111;
   localparam logic [2:0] f3Word = 3'b010; // lw / sw

   localparam logic [6:0] f7Norm = 7'b0000000;
   localparam logic [6:0] f7Alt  = 7'b0100000;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSlt, aluSltu, aluXor,
      aluOr, aluAnd, aluSll, aluSrl, aluSra
   } aluOpT;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rFormatT;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iFormatT;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sFormatT;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uFormatT;

   typedef union packed {
      rFormatT r;
      iFormatT i;
      sFormatT s;
      uFormatT u;
   } instrWordT;

   typedef struct packed {
      aluOpT                aluOp;
      logic                 useImm;
      logic [xlen-1:0]      imm;
      logic [regAddrW-1:0]  rs1;
      logic [regAddrW-1:0]  rs2;
      logic [regAddrW-1:0]  rd;
      logic                 writesRd;
      logic                 isLui;
      logic                 isLoad;
      logic                 isStore;
      logic                 stop; // halt opcode or bad encoding
   } decodedOpT;

   typedef struct packed {
      logic            req;
      logic            we;
      logic [xlen-1:0] addr; // word address
      logic [xlen-1:0] wdata;
   } memReqT;

   typedef struct packed {
      logic                en;
      logic [regAddrW-1:0] addr;
      logic [xlen-1:0]     data;
   } regWriteT;

endpackage

`default_nettype wire

// File: lanzonesFetch.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesFetch (
   input  wire logic                            clk,
   input  wire logic                            rstn,
   input  wire logic                            loadEn,
   input  wire logic                            memVld,
   input  wire logic [lanzonesPkg::xlen-1:0]    memRData,
   input  lanzonesPkg::decodedOpT               op,
   input  wire logic [lanzonesPkg::xlen-1:0]    dataAddr,
   input  wire logic [lanzonesPkg::xlen-1:0]    storeData,
   output lanzonesPkg::memReqT                  memReq,
   output lanzonesPkg::instrWordT               instr,
   output logic                                 instrVld,
   output logic                                 loadVld,
   output logic                                 halt,
   output logic [lanzonesPkg::xlen-1:0]         loadData
);

   typedef enum logic [2:0] {idle, fetch, decode, access, halted} stateT;

   stateT                          state;
   logic [lanzonesPkg::xlen-1:0]   pc;       // counts words
   lanzonesPkg::instrWordT         instrQ;
   logic [lanzonesPkg::xlen-1:0]   accAddr;
   logic [lanzonesPkg::xlen-1:0]   accWData;
   logic                           accWe;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= idle;
         halt  <= 1'b1;
         pc    <= '0;
         accWe <= 1'b0;
      end else begin
         case (state)
            idle, halted: begin
               if (loadEn) begin
                  state <= fetch;
                  halt  <= 1'b0;
               end
            end
            fetch: begin
               if (memVld) begin
                  state <= decode;
                  pc    <= pc + 1'b1;
               end
            end
            decode: begin
               if (op.stop) begin
                  state <= halted;
                  halt  <= 1'b1;
               end else if (op.isLoad || op.isStore) begin
                  state <= access;
                  accWe <= op.isStore;
               end else begin
                  state <= fetch;
               end
            end
            access: if (memVld) state <= fetch;
            default: state <= idle;
         endcase
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (state == fetch && memVld) instrQ <= memRData;
      if (state == decode) begin
         accAddr  <= dataAddr;
         accWData <= storeData;
      end
   end

   always_comb begin
      memReq.req   = (state == fetch) || (state == access);
      memReq.we    = (state == access) && accWe;
      memReq.addr  = (state == access) ? accAddr : pc;
      memReq.wdata = memReq.we ? accWData : '0;
   end

   assign instr    = instrQ;
   assign instrVld = (state == decode);
   assign loadVld  = (state == access) && !accWe && memVld;
   assign loadData = memRData;

   // request held until the memory answers
   assert property (@(posedge clk) disable iff (!rstn)
      memReq.req && !memVld |=> $stable(memReq));

endmodule

`default_nettype wire

// File: lanzonesDecode.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesDecode (
   input  lanzonesPkg::instrWordT   instr,
   input  wire logic                instrVld,
   output lanzonesPkg::decodedOpT   op
);

   always_comb begin
      logic bad;
      bad = 1'b0;
      op  = '0;
      if (instrVld) begin
         case (instr.r.opcode)
            lanzonesPkg::opOpImm: begin
               op.rs1      = instr.i.rs1;
               op.rd       = instr.i.rd;
               op.useImm   = 1'b1;
               op.writesRd = 1'b1;
               op.imm      = {{20{instr.i.imm[11]}}, instr.i.imm};
               case (instr.i.funct3)
                  lanzonesPkg::f3Add:  op.aluOp = lanzonesPkg::aluAdd;
                  lanzonesPkg::f3Slt:  op.aluOp = lanzonesPkg::aluSlt;
                  lanzonesPkg::f3Sltu: op.aluOp = lanzonesPkg::aluSltu;
                  lanzonesPkg::f3Xor:  op.aluOp = lanzonesPkg::aluXor;
                  lanzonesPkg::f3Or:   op.aluOp = lanzonesPkg::aluOr;
                  lanzonesPkg::f3And:  op.aluOp = lanzonesPkg::aluAnd;
                  lanzonesPkg::f3Sll: begin
                     op.aluOp = lanzonesPkg::aluSll;
                     op.imm   = {27'b0, instr.r.rs2}; // shamt
                     bad      = instr.r.funct7 != lanzonesPkg::f7Norm;
                  end
                  default: begin // srli / srai
                     op.imm = {27'b0, instr.r.rs2};
                     if (instr.r.funct7 == lanzonesPkg::f7Alt) begin
                        op.aluOp = lanzonesPkg::aluSra;
                     end else begin
                        op.aluOp = lanzonesPkg::aluSrl;
                        bad      = instr.r.funct7 != lanzonesPkg::f7Norm;
                     end
                  end
               endcase
            end
            lanzonesPkg::opOp: begin
               op.rs1      = instr.r.rs1;
               op.rs2      = instr.r.rs2;
               op.rd       = instr.r.rd;
               op.writesRd = 1'b1;
               if (instr.r.funct7 == lanzonesPkg::f7Norm) begin
                  case (instr.r.funct3)
                     lanzonesPkg::f3Add:  op.aluOp = lanzonesPkg::aluAdd;
                     lanzonesPkg::f3Sll:  op.aluOp = lanzonesPkg::aluSll;
                     lanzonesPkg::f3Slt:  op.aluOp = lanzonesPkg::aluSlt;
                     lanzonesPkg::f3Sltu: op.aluOp = lanzonesPkg::aluSltu;
                     lanzonesPkg::f3Xor:  op.aluOp = lanzonesPkg::aluXor;
                     lanzonesPkg::f3Or:   op.aluOp = lanzonesPkg::aluOr;
                     lanzonesPkg::f3And:  op.aluOp = lanzonesPkg::aluAnd;
                     default:             bad      = 1'b1; // no srl in this subset
                  endcase
               end else if (instr.r.funct7 == lanzonesPkg::f7Alt &&
                            instr.r.funct3 == lanzonesPkg::f3Add) begin
                  op.aluOp = lanzonesPkg::aluSub;
               end else begin
                  bad = 1'b1;
               end
            end
            lanzonesPkg::opLui: begin
               op.rd       = instr.u.rd;
               op.imm      = {12'b0, instr.u.imm}; // shifted up in write-back
               op.isLui    = 1'b1;
               op.writesRd = 1'b1;
            end
            lanzonesPkg::opStore: begin
               op.rs1     = instr.s.rs1;
               op.rs2     = instr.s.rs2;
               op.imm     = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
               op.useImm  = 1'b1;
               op.isStore = 1'b1;
               bad        = instr.s.funct3 != lanzonesPkg::f3Word;
            end
            lanzonesPkg::opLoad: begin
               op.rs1    = instr.i.rs1;
               op.rd     = instr.i.rd;
               op.imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
               op.useImm = 1'b1;
               op.isLoad = 1'b1; // rd written later by write-back
               bad       = instr.i.funct3 != lanzonesPkg::f3Word;
            end
            default: bad = 1'b1; // includes opHalt
         endcase
         // a stopping word has no other effect
         if (bad) begin
            op      = '0;
            op.stop = 1'b1;
         end
      end
      assert final ($onehot0({op.isLoad, op.isStore, op.writesRd}));
   end

endmodule

`default_nettype wire

// File: lanzonesAlu.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesAlu (
   input  lanzonesPkg::decodedOpT             op,
   input  wire logic [lanzonesPkg::xlen-1:0]  rs1Data,
   input  wire logic [lanzonesPkg::xlen-1:0]  rs2Data,
   output logic [lanzonesPkg::xlen-1:0]       aluResult
);

   logic [lanzonesPkg::xlen-1:0] opB;
   logic [4:0]                   shamt;

   assign opB   = op.useImm ? op.imm : rs2Data;
   assign shamt = opB[4:0];

   always_comb begin
      case (op.aluOp)
         lanzonesPkg::aluAdd:  aluResult = rs1Data + opB; // also load/store address
         lanzonesPkg::aluSub:  aluResult = rs1Data - opB;
         lanzonesPkg::aluSlt: begin
            aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
         end
         lanzonesPkg::aluSltu: begin
            aluResult = {31'b0, rs1Data < opB};
         end
         lanzonesPkg::aluXor:  aluResult = rs1Data ^ opB;
         lanzonesPkg::aluOr:   aluResult = rs1Data | opB;
         lanzonesPkg::aluAnd:  aluResult = rs1Data & opB;
         lanzonesPkg::aluSll:  aluResult = rs1Data << shamt;
         lanzonesPkg::aluSrl:  aluResult = rs1Data >> shamt;
         lanzonesPkg::aluSra:  aluResult = $unsigned($signed(rs1Data) >>> shamt);
         default:              aluResult = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: lanzonesRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesRegFile (
   input  wire logic                                clk,
   input  wire logic                                rstn,
   input  wire logic [lanzonesPkg::regAddrW-1:0]    rs1,
   input  wire logic [lanzonesPkg::regAddrW-1:0]    rs2,
   input  lanzonesPkg::regWriteT                    regWrite,
   output logic [lanzonesPkg::xlen-1:0]             rs1Data,
   output logic [lanzonesPkg::xlen-1:0]             rs2Data
);

   logic [lanzonesPkg::xlen-1:0] regs [lanzonesPkg::numRegs];

   // x0 cleared in reset and never written
   always_ff @(posedge clk) begin
      if (!rstn) begin
         regs[0] <= '0;
      end else if (regWrite.en && regWrite.addr != '0) begin
         regs[regWrite.addr] <= regWrite.data;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

   assert property (@(posedge clk) disable iff (!rstn)
      rs1 == '0 |-> rs1Data == '0);

endmodule

`default_nettype wire

// File: lanzonesWriteback.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesWriteback (
   input  wire logic                            clk,
   input  wire logic                            rstn,
   input  lanzonesPkg::decodedOpT               op,
   input  wire logic [lanzonesPkg::xlen-1:0]    aluResult,
   input  wire logic                            loadVld,
   input  wire logic [lanzonesPkg::xlen-1:0]    loadData,
   output lanzonesPkg::regWriteT                regWrite
);

   logic                                 loadPending;
   logic [lanzonesPkg::regAddrW-1:0]     loadRd;
   logic                                 wrEn;
   logic [lanzonesPkg::regAddrW-1:0]     wrAddr;
   logic [lanzonesPkg::xlen-1:0]         wrData;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wrEn        <= 1'b0;
         loadPending <= 1'b0;
      end else begin
         wrEn <= op.writesRd || (loadPending && loadVld);
         if (op.isLoad) loadPending <= 1'b1;
         else if (loadVld) loadPending <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (op.isLoad) loadRd <= op.rd;
      if (op.writesRd) begin
         wrAddr <= op.rd;
         wrData <= op.isLui ? (op.imm << 12) : aluResult;
      end else if (loadPending && loadVld) begin
         wrAddr <= loadRd;
         wrData <= loadData;
      end
   end

   assign regWrite = '{en: wrEn, addr: wrAddr, data: wrData};

endmodule

`default_nettype wire

// File: lanzones.sv
`timescale 1ns/100ps
`default_nettype none

module lanzones (
   input  wire logic                            clk,
   input  wire logic                            rstn,
   input  wire logic                            loadEn,
   input  wire logic                            memVld,
   input  wire logic [lanzonesPkg::xlen-1:0]    memRData,
   output lanzonesPkg::memReqT                  memReq,
   output logic                                 halt
);

   lanzonesPkg::instrWordT          instr;
   logic                            instrVld;
   lanzonesPkg::decodedOpT          op;
   logic [lanzonesPkg::xlen-1:0]    aluResult;
   logic [lanzonesPkg::xlen-1:0]    rs1Data;
   logic [lanzonesPkg::xlen-1:0]    rs2Data;
   logic                            loadVld;
   logic [lanzonesPkg::xlen-1:0]    loadData;
   lanzonesPkg::regWriteT           regWrite;

   lanzonesFetch uFetch (
      .clk       (clk),
      .rstn      (rstn),
      .loadEn    (loadEn),
      .memVld    (memVld),
      .memRData  (memRData),
      .op        (op),
      .dataAddr  (aluResult),
      .storeData (rs2Data),
      .memReq    (memReq),
      .instr     (instr),
      .instrVld  (instrVld),
      .loadVld   (loadVld),
      .halt      (halt),
      .loadData  (loadData)
   );

   lanzonesDecode uDecode (.instr(instr), .instrVld(instrVld), .op(op));

   lanzonesAlu uAlu (.op(op), .rs1Data(rs1Data), .rs2Data(rs2Data), .aluResult(aluResult));

   lanzonesRegFile uRegFile (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (op.rs1),
      .rs2      (op.rs2),
      .regWrite (regWrite),
      .rs1Data  (rs1Data),
      .rs2Data  (rs2Data)
   );

   lanzonesWriteback uWriteback (
      .clk       (clk),
      .rstn      (rstn),
      .op        (op),
      .aluResult (aluResult),
      .loadVld   (loadVld),
      .loadData  (loadData),
      .regWrite  (regWrite)
   );

endmodule

`default_nettype wire

// File: lanzonesTbClock.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesTbClock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      rstn = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

`default_nettype wire

// File: lanzonesTbMem.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesTbMem (
   input  wire logic                 clk,
   input  wire logic                 rstn,
   input  wire lanzonesPkg::memReqT  memReq,
   output logic                      memVld,
   output logic [31:0]               memRData
);

   logic [31:0] words [256];
   logic [31:0] lcgState;
   logic [31:0] rnd;
   int          countdown;
   logic        busy;

   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   initial begin
      int i;
      lcgState  = 32'd16363;
      memVld    = 1'b0;
      memRData  = '0;
      busy      = 1'b0;
      countdown = 0;
      for (i = 0; i < 256; i++) words[i] = {16'hE5A0, i[7:0], ~i[7:0]};
   end

   // answer 1 to 4 cycles after req rises
   always @(negedge clk) begin
      if (!rstn || memVld) begin
         memVld <= 1'b0;
         busy = 1'b0;
      end else if (memReq.req) begin
         if (!busy) begin
            rnd       = nextRandom();
            countdown = 1 + rnd[17:16];
            busy      = 1'b1;
         end
         countdown--;
         if (countdown == 0) begin
            memVld   <= 1'b1;
            memRData <= words[memReq.addr[7:0]];
         end
      end
   end

   always @(posedge clk) begin
      if (rstn && memVld && memReq.req && memReq.we) words[memReq.addr[7:0]] <= memReq.wdata;
   end

endmodule

`default_nettype wire

// File: lanzonesTb.sv
`timescale 1ns/100ps
`default_nettype none

module lanzonesTb;

   logic                clk;
   logic                rstn;
   logic                loadEn;
   logic                memVld;
   logic                halt;
   logic                started;
   logic                dataNext; // next completed request is a data access
   logic [31:0]         memRData;
   logic [31:0]         expPc;
   lanzonesPkg::memReqT memReq;
   logic [31:0]         expAddr [64];
   logic [31:0]         expData [64];
   int                  storeIdx;
   int                  expCount;
   int                  errCount;
   int                  testNum;
   int                  testsFailed;
   int unsigned         progAddr;
   int unsigned         storeAddr;

   lanzonesTbClock clockGen (.clk(clk), .rstn(rstn));

   lanzones dut0 (.clk(clk), .rstn(rstn), .loadEn(loadEn), .memVld(memVld),
      .memRData(memRData), .memReq(memReq), .halt(halt));

   lanzonesTbMem memModel (.clk(clk), .rstn(rstn), .memReq(memReq), .memVld(memVld),
      .memRData(memRData));

   always @(posedge clk) begin
      if (!rstn) begin
         expPc    <= '0;
         dataNext <= 1'b0;
         storeIdx <= 0;
      end else if (memReq.req && memVld) begin
         dataNext <= !dataNext && (memRData[6:0] == lanzonesPkg::opLoad ||
                                   memRData[6:0] == lanzonesPkg::opStore);
         if (!dataNext) expPc <= expPc + 1;
         if (memReq.we) storeIdx <= storeIdx + 1;
      end
   end

   assert property (@(posedge clk) disable iff (!rstn) !started |-> halt && !memReq.req)
      else begin
         errCount++;
         $display("core left its reset state before loadEn");
      end

   assert property (@(posedge clk) disable iff (!rstn)
      memReq.req && !dataNext |-> memReq.addr == expPc)
      else begin
         errCount++;
         $display("ERROR memReq.addr: got %h expected %h", $sampled(memReq.addr), $sampled(expPc));
      end

   assert property (@(posedge clk) disable iff (!rstn) memReq.req && !memVld |=> $stable(memReq))
      else begin
         errCount++;
         $display("request changed while waiting for memVld");
      end

   assert property (@(posedge clk) disable iff (!rstn) halt |-> !memReq.req)
      else begin
         errCount++;
         $display("request issued while halted");
      end

   assert property (@(posedge clk) disable iff (!rstn)
      memReq.req && memReq.we && memVld |-> storeIdx < expCount)
      else begin
         errCount++;
         $display("unexpected store to word %h", $sampled(memReq.addr));
      end

   assert property (@(posedge clk) disable iff (!rstn) memReq.req && memReq.we && memVld
      |-> storeIdx >= expCount || memReq.addr == expAddr[storeIdx])
      else begin
         errCount++;
         $display("ERROR memReq.addr: got %h expected %h", $sampled(memReq.addr),
            expAddr[$sampled(storeIdx)]);
      end

   assert property (@(posedge clk) disable iff (!rstn) memReq.req && memReq.we && memVld
      |-> storeIdx >= expCount || memReq.wdata == expData[storeIdx])
      else begin
         errCount++;
         $display("ERROR memReq.wdata: got %h expected %h", $sampled(memReq.wdata),
            expData[$sampled(storeIdx)]);
      end

   function automatic logic [31:0] immOp(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd);
      return {imm, rs1, f3, rd, lanzonesPkg::opOpImm};
   endfunction

   function automatic logic [31:0] regOp(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, lanzonesPkg::opOp};
   endfunction

   task automatic addWord(logic [31:0] word);
      memModel.words[progAddr] = word;
      progAddr++;
   endtask

   // instruction, then a sw of its rd to the next data word
   task automatic opAndStore(logic [31:0] word, logic [4:0] rd, logic [31:0] value);
      addWord(word);
      addWord({storeAddr[11:5], rd, 5'd0, lanzonesPkg::f3Word, storeAddr[4:0],
               lanzonesPkg::opStore});
      expAddr[expCount] = storeAddr;
      expData[expCount] = value;
      expCount++;
      storeAddr++;
   endtask

   task automatic runProgram(int unsigned endPc);
      int i;
      @(negedge clk);
      loadEn  = 1'b1;
      started = 1'b1;
      @(negedge clk);
      loadEn = 1'b0;
      for (i = 0; i < 3000 && !halt; i++) @(negedge clk);
      if (!halt) begin
         errCount++;
         $display("timeout waiting for halt after fetch %0d", expPc);
      end else begin
         assert (expPc == endPc) else begin
            errCount++;
            $display("ERROR fetch count: got %h expected %h", expPc, endPc);
         end
         assert (storeIdx == expCount) else begin
            errCount++;
            $display("ERROR storeIdx: got %h expected %h", storeIdx, expCount);
         end
      end
   endtask

   task automatic reportTest(string name, int errBefore);
      testNum++;
      if (errCount == errBefore) begin
         $display("test %0d %s: ok", testNum, name);
      end else begin
         testsFailed++;
         $display("test %0d %s: %0d checks failed", testNum, name, errCount - errBefore);
      end
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] lui;
      int          errBefore;
      int          stopAt;
      int          i;
      a           = 32'hFFFFFFF9;
      b           = 32'd5;
      lui         = 32'h80001 << 12;
      loadEn      = 1'b0;
      started     = 1'b0;
      errCount    = 0;
      testNum     = 0;
      testsFailed = 0;
      expCount    = 0;
      progAddr    = 0;
      storeAddr   = 128;
      for (i = 0; i < 100 && !rstn; i++) @(negedge clk);
      if (!rstn) begin
         errCount++;
         $display("timeout waiting for reset release");
      end

      errBefore = errCount;
      repeat (20) @(negedge clk); // idle until loadEn
      opAndStore(immOp(12'd1, 0, lanzonesPkg::f3Add, 1), 1, 32'd1);
      addWord(32'h0000007F);
      runProgram(progAddr);
      reportTest("reset and fetch order", errBefore);

      errBefore = errCount;
      opAndStore(immOp(12'hFF9, 0, lanzonesPkg::f3Add, 1), 1, a);
      opAndStore(immOp(12'd5, 0, lanzonesPkg::f3Add, 2), 2, b);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3Slt, 3), 3,
                 $signed(a) < $signed(b));
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3Sltu, 4), 4, a < b);
      opAndStore(immOp(12'hFFD, 1, lanzonesPkg::f3Slt, 5), 5, $signed(a) < -3);
      opAndStore(immOp(12'hFFF, 2, lanzonesPkg::f3Sltu, 6), 6, b < 32'hFFFFFFFF);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3Add, 7), 7, a + b);
      opAndStore(regOp(lanzonesPkg::f7Alt, 1, 2, lanzonesPkg::f3Add, 8), 8, b - a);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3Xor, 9), 9, a ^ b);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3Or, 10), 10, a | b);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 1, lanzonesPkg::f3And, 11), 11, a & b);
      opAndStore(immOp(12'h555, 1, lanzonesPkg::f3Xor, 12), 12, a ^ 32'h555);
      opAndStore(immOp(12'h7F0, 2, lanzonesPkg::f3Or, 13), 13, b | 32'h7F0);
      opAndStore(immOp(12'hF0F, 1, lanzonesPkg::f3And, 14), 14, a & 32'hFFFFFF0F);
      opAndStore(regOp(lanzonesPkg::f7Norm, 2, 2, lanzonesPkg::f3Sll, 15), 15, b << b[4:0]);
      addWord(32'h0000007F);
      runProgram(progAddr);
      reportTest("register and immediate ops", errBefore);

      errBefore = errCount;
      opAndStore({20'h80001, 5'd16, lanzonesPkg::opLui}, 16, lui);
      opAndStore(immOp({7'd0, 5'd3}, 16, lanzonesPkg::f3Sll, 17), 17, lui << 3);
      opAndStore(immOp({7'd0, 5'd4}, 16, lanzonesPkg::f3Srl, 18), 18, lui >> 4);
      opAndStore(immOp({lanzonesPkg::f7Alt, 5'd4}, 16, lanzonesPkg::f3Srl, 19), 19,
                 $signed(lui) >>> 4);
      addWord(32'h0000007F);
      runProgram(progAddr);
      reportTest("lui and shifts", errBefore);

      errBefore = errCount;
      memModel.words[180] = 32'h13579BDF;
      memModel.words[181] = 32'h2468ACE0;
      opAndStore({12'd180, 5'd0, lanzonesPkg::f3Word, 5'd20, lanzonesPkg::opLoad}, 20,
                 32'h13579BDF);
      opAndStore(immOp(12'd170, 0, lanzonesPkg::f3Add, 22), 22, 32'd170);
      opAndStore({12'd11, 5'd22, lanzonesPkg::f3Word, 5'd23, lanzonesPkg::opLoad}, 23,
                 32'h2468ACE0); // base plus offset
      addWord(32'h0000007F);
      runProgram(progAddr);
      reportTest("load and store", errBefore);

      errBefore = errCount;
      opAndStore(immOp(12'h123, 0, lanzonesPkg::f3Add, 24), 24, 32'h123);
      addWord(32'hABCDE07F);
      runProgram(progAddr);
      repeat (50) @(negedge clk); // no request while halted
      opAndStore(immOp(12'h321, 0, lanzonesPkg::f3Add, 25), 25, 32'h321);
      addWord(32'h0000007F);
      runProgram(progAddr);
      reportTest("halt and resume", errBefore);

      errBefore = errCount;
      stopAt = progAddr;
      addWord(regOp(lanzonesPkg::f7Alt, 2, 1, lanzonesPkg::f3Sll, 26));
      addWord({7'd4, 5'd2, 5'd0, lanzonesPkg::f3Word, 5'd31, lanzonesPkg::opStore});
      addWord(32'h0000007F);
      runProgram(stopAt + 1);
      reportTest("invalid encoding", errBefore);

      $display("tests run %0d, tests failed %0d, checks failed %0d", testNum, testsFailed,
               errCount);
      if (errCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: lanzones.f
lanzonesPkg.sv
lanzonesFetch.sv
lanzonesDecode.sv
lanzonesAlu.sv
lanzonesRegFile.sv
lanzonesWriteback.sv
lanzones.sv
lanzonesTbClock.sv
lanzonesTbMem.sv
lanzonesTb.sv

// File: Bender.yml
package:
  name: lanzones

sources:
  - lanzonesPkg.sv
  - lanzonesFetch.sv
  - lanzonesDecode.sv
  - lanzonesAlu.sv
  - lanzonesRegFile.sv
  - lanzonesWriteback.sv
  - lanzones.sv
  - target: test
    files:
      - lanzonesTbClock.sv
      - lanzonesTbMem.sv
      - lanzonesTb.sv
